// File: src.f
+incdir+design
design/cnn_pkg.sv
design/step_if.sv
design/engine_ctrl.sv
design/window_counter.sv
design/window_accumulator.sv
design/result_buffer.sv
design/cnn_engine.sv
tb/cnn_engine_asserts.sv
tb/tb_cnn_engine.sv

// File: run.sh
#!/bin/sh
# Build and run the cnn_engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_cnn_engine -o sim_tb
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "NO ERRORS"; then
	exit 0
fi
exit 1

// File: tb/tb_cnn_engine.sv
`timescale 1ns/100ps

module tb_cnn_engine import cnn_pkg::*; ();

	logic clk;
	logic i_reset;
	logic i_engine_valid;
	op_t i_op_type;
	stride_t i_stride;
	count_t i_kernel_size;
	count_t i_o_count;
	addr_t i_data_start_addr;
	addr_t i_weight_start_addr;
	addr_t i_result_start_addr;
	logic o_engine_ready;
	logic o_data_rd_en;
	addr_t o_data_addr;
	logic i_data_we;
	word_t i_data;
	logic o_weight_rd_en;
	addr_t o_weight_addr;
	logic i_weight_we;
	word_t i_weight;
	logic o_result_wr_en;
	addr_t o_result_addr;
	word_t o_result_data;
	logic i_result_re;

	word_t data_mem [256];
	word_t weight_mem [256];
	word_t result_mem [256];
	logic [15:0] lfsr = 16'd46920;
	int cycles = 0;
	int read_count = 0;
	int write_count = 0;
	int ready_count = 0;
	int hold_cycles = 0;
	logic weight_seen = 1'b0;

	cnn_engine cnn_engine_inst (.*);

	bind cnn_engine cnn_engine_asserts u_asserts (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 20000) begin
			$display("Timeout, the engine hung without finishing");
			$display("ERRORS FOUND");
			$fatal(1);
		end
	end

	always @(posedge clk) begin
		if (o_engine_ready) ready_count++;
		if (o_weight_rd_en) weight_seen = 1'b1;
	end

	// Taps 16,14,13,11
	function logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function int rand_delay();
		int hi;
		int lo;
		hi = int'(lfsr_bit());
		lo = int'(lfsr_bit());
		return 1 + 2 * hi + lo;
	endfunction

	task check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// DMA read side, data words
	initial begin : data_dma
		int d;
		addr_t a;
		forever begin
			@(posedge clk);
			if (o_data_rd_en) begin
				d = rand_delay();
				a = o_data_addr;
				repeat (d - 1) @(posedge clk);
				i_data_we <= 1'b1;
				i_data <= data_mem[a[7:0]];
				read_count++;
				@(posedge clk);
				i_data_we <= 1'b0;
			end
		end
	end

	initial begin : weight_dma
		int d;
		addr_t a;
		forever begin
			@(posedge clk);
			if (o_weight_rd_en) begin
				d = rand_delay();
				a = o_weight_addr;
				repeat (d - 1) @(posedge clk);
				i_weight_we <= 1'b1;
				i_weight <= weight_mem[a[7:0]];
				read_count++;
				@(posedge clk);
				i_weight_we <= 1'b0;
			end
		end
	end

	// DMA write side, optionally held back
	initial begin : result_dma
		int d;
		int rc;
		forever begin
			@(posedge clk);
			if (o_result_wr_en) begin
				d = (hold_cycles > 0) ? hold_cycles : rand_delay();
				rc = read_count;
				repeat (d - 1) @(posedge clk);
				if (hold_cycles > 0) check("read_count", read_count, rc);
				i_result_re <= 1'b1;
				result_mem[o_result_addr[7:0]] = o_result_data;
				write_count++;
				@(posedge clk);
				i_result_re <= 1'b0;
			end
		end
	end

	function automatic word_t expect_conv(int ds, int ws, int s, int ks, int k);
		longint sum;
		sum = 0;
		for (int j = 0; j < ks; j++) begin
			sum += longint'(data_mem[(ds + k * s + j) % 256]) *
				longint'(weight_mem[(ws + j) % 256]);
		end
		sum = sum >>> 8;
		if (sum > 32767) return 16'sh7FFF;
		if (sum < -32768) return 16'sh8000;
		return word_t'(sum);
	endfunction

	function automatic word_t expect_max(int ds, int s, int ks, int k);
		word_t m;
		m = data_mem[(ds + k * s) % 256];
		for (int j = 1; j < ks; j++) begin
			if (data_mem[(ds + k * s + j) % 256] > m) m = data_mem[(ds + k * s + j) % 256];
		end
		return m;
	endfunction

	task run_engine(input op_t op, input int s, input int ks, input int oc,
		input int ds, input int ws, input int rs);
		@(posedge clk);
		read_count = 0;
		write_count = 0;
		ready_count = 0;
		weight_seen = 1'b0;
		i_op_type <= op;
		i_stride <= stride_t'(s);
		i_kernel_size <= count_t'(ks);
		i_o_count <= count_t'(oc);
		i_data_start_addr <= addr_t'(ds);
		i_weight_start_addr <= addr_t'(ws);
		i_result_start_addr <= addr_t'(rs);
		i_engine_valid <= 1'b1;
		do @(posedge clk); while (!o_engine_ready);
		i_engine_valid <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task conv_test(input int s, input int ks, input int oc, input int ds,
		input int ws, input int rs);
		run_engine(OP_CONV, s, ks, oc, ds, ws, rs);
		check("write_count", write_count, oc);
		for (int k = 0; k < oc; k++) begin
			check("o_result_data", result_mem[rs + k], expect_conv(ds, ws, s, ks, k));
		end
	endtask

	task saturation_test();
		for (int a = 32; a < 48; a++) begin
			data_mem[a] = (a < 38) ? 16'sh4000 : -16'sh4000;
		end
		for (int a = 100; a < 103; a++) weight_mem[a] = 16'sh4000;
		conv_test(2, 3, 4, 32, 100, 210);
		check("o_result_data", result_mem[210], 32'h0000_7FFF);
		check("o_result_data", result_mem[213], 32'hFFFF_8000);
	endtask

	task maxpool_test();
		run_engine(OP_MAXPOOL, 3, 4, 3, 60, 0, 220);
		check("write_count", write_count, 3);
		check("o_weight_rd_en", weight_seen, 0);
		for (int k = 0; k < 3; k++) begin
			check("o_result_data", result_mem[220 + k], expect_max(60, 3, 4, k));
		end
	endtask

	task unsupported_test();
		run_engine(op_t'(3'd2), 1, 3, 2, 0, 0, 0);
		check("read_count", read_count, 0);
		check("write_count", write_count, 0);
		check("o_engine_ready", ready_count, 1);
		// Second run, then valid stays high and must not restart
		i_engine_valid <= 1'b1;
		@(posedge clk);
		do @(posedge clk); while (!o_engine_ready);
		repeat (10) @(posedge clk);
		check("o_engine_ready", ready_count, 2);
		i_engine_valid <= 1'b0;
		repeat (2) @(posedge clk);
		i_engine_valid <= 1'b1;
		do @(posedge clk); while (!o_engine_ready);
		i_engine_valid <= 1'b0;
		@(posedge clk);
		check("o_engine_ready", ready_count, 3);
	endtask

	initial begin
		i_reset = 1'b1;
		i_engine_valid = 1'b0;
		i_op_type = OP_CONV;
		i_stride = '0;
		i_kernel_size = '0;
		i_o_count = '0;
		i_data_start_addr = '0;
		i_weight_start_addr = '0;
		i_result_start_addr = '0;
		i_data_we = 1'b0;
		i_data = '0;
		i_weight_we = 1'b0;
		i_weight = '0;
		i_result_re = 1'b0;
		// Small signed Q8.8 values, roughly -1.0 to 1.0
		for (int a = 0; a < 256; a++) begin
			data_mem[a] = word_t'(((a * 29 + 7) % 512) - 256);
			weight_mem[a] = word_t'(((a * 53 + 11) % 512) - 256);
			result_mem[a] = '0;
		end
		repeat (3) @(posedge clk);
		i_reset <= 1'b0;
		@(posedge clk);
		check("o_engine_ready", o_engine_ready, 0);
		check("o_data_rd_en", o_data_rd_en, 0);
		check("o_weight_rd_en", o_weight_rd_en, 0);
		check("o_result_wr_en", o_result_wr_en, 0);
		conv_test(1, 5, 4, 16, 100, 200);
		saturation_test();
		maxpool_test();
		unsupported_test();
		// Result strobe withheld, no reads while waiting
		hold_cycles = 30;
		conv_test(1, 2, 2, 70, 120, 230);
		hold_cycles = 0;
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: tb/cnn_engine_asserts.sv
`timescale 1ns/100ps

module cnn_engine_asserts import cnn_pkg::*; (
	input logic  clk,
	input logic  i_reset,
	input logic  o_engine_ready,
	input logic  o_data_rd_en,
	input logic  i_data_we,
	input logic  o_weight_rd_en,
	input logic  i_weight_we,
	input logic  o_result_wr_en,
	input addr_t o_result_addr,
	input word_t o_result_data,
	input logic  i_result_re
);

	// Done is a pulse, never a level
	ready_pulse: assert property (@(posedge clk) disable iff (i_reset)
		o_engine_ready |=> !o_engine_ready)
		else $error("engine ready held longer than one cycle");

	result_hold: assert property (@(posedge clk) disable iff (i_reset)
		o_result_wr_en && !i_result_re |=>
		o_result_wr_en && $stable(o_result_data) && $stable(o_result_addr))
		else $error("result write dropped or changed before the read strobe");

	data_fall: assert property (@(posedge clk) disable iff (i_reset)
		o_data_rd_en && i_data_we |=> !o_data_rd_en)
		else $error("data read enable still high after its strobe");

	weight_fall: assert property (@(posedge clk) disable iff (i_reset)
		o_weight_rd_en && i_weight_we |=> !o_weight_rd_en)
		else $error("weight read enable still high after its strobe");

	reset_quiet: assert property (@(posedge clk)
		i_reset |=> !o_engine_ready && !o_data_rd_en && !o_weight_rd_en && !o_result_wr_en)
		else $error("control output high after reset");

endmodule

// File: design/cnn_engine.sv
`timescale 1ns/100ps

module cnn_engine import cnn_pkg::*; (
	input  logic    clk,
	input  logic    i_reset,
	input  logic    i_engine_valid,
	input  op_t     i_op_type,
	input  stride_t i_stride,
	input  count_t  i_kernel_size,
	input  count_t  i_o_count,
	input  addr_t   i_data_start_addr,
	input  addr_t   i_weight_start_addr,
	input  addr_t   i_result_start_addr,
	output logic    o_engine_ready,
	output logic    o_data_rd_en,
	output addr_t   o_data_addr,
	input  logic    i_data_we,
	input  word_t   i_data,
	output logic    o_weight_rd_en,
	output addr_t   o_weight_addr,
	input  logic    i_weight_we,
	input  word_t   i_weight,
	output logic    o_result_wr_en,
	output addr_t   o_result_addr,
	output word_t   o_result_data,
	input  logic    i_result_re
);

	logic fetch;
	logic clear;
	logic load;
	logic accepted;
	logic pair_done;
	acc_t acc;

	step_if st ();

	engine_ctrl u_ctrl (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_engine_valid (i_engine_valid),
		.i_op_type      (i_op_type),
		.i_pair_done    (pair_done),
		.i_accepted     (accepted),
		.st             (st.ctrl),
		.o_fetch        (fetch),
		.o_clear        (clear),
		.o_load         (load),
		.o_engine_ready (o_engine_ready)
	);

	window_counter u_counter (
		.clk                 (clk),
		.i_reset             (i_reset),
		.i_stride            (i_stride),
		.i_kernel_size       (i_kernel_size),
		.i_o_count           (i_o_count),
		.i_data_start_addr   (i_data_start_addr),
		.i_weight_start_addr (i_weight_start_addr),
		.i_result_start_addr (i_result_start_addr),
		.st                  (st.cnt),
		.o_data_addr         (o_data_addr),
		.o_weight_addr       (o_weight_addr),
		.o_result_addr       (o_result_addr)
	);

	window_accumulator u_acc (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_op_type      (i_op_type),
		.i_fetch        (fetch),
		.i_clear        (clear),
		.i_data_we      (i_data_we),
		.i_data         (i_data),
		.i_weight_we    (i_weight_we),
		.i_weight       (i_weight),
		.o_data_rd_en   (o_data_rd_en),
		.o_weight_rd_en (o_weight_rd_en),
		.o_pair_done    (pair_done),
		.o_acc          (acc)
	);

	result_buffer u_result (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_op_type      (i_op_type),
		.i_load         (load),
		.i_acc          (acc),
		.i_result_re    (i_result_re),
		.o_result_wr_en (o_result_wr_en),
		.o_result_data  (o_result_data),
		.o_accepted     (accepted)
	);

endmodule

// File: design/result_buffer.sv
`timescale 1ns/100ps
`include "cnn_defs.svh"

module result_buffer import cnn_pkg::*; (
	input  logic  clk,
	input  logic  i_reset,
	input  op_t   i_op_type,
	input  logic  i_load,
	input  acc_t  i_acc,
	input  logic  i_result_re,
	output logic  o_result_wr_en,
	output word_t o_result_data,
	output logic  o_accepted
);

	localparam acc_t WORD_MAX = (acc_t'(1) <<< (`WORD_W - 1)) - acc_t'(1);
	localparam acc_t WORD_MIN = -(acc_t'(1) <<< (`WORD_W - 1));

	acc_t shifted;
	word_t result;

	// Back from Q16.16 products to Q8.8
	assign shifted = i_acc >>> `FRAC_BITS;

	always_comb begin
		if (i_op_type != OP_CONV) begin
			result = i_acc[`WORD_W-1:0];
		end else if (shifted > WORD_MAX) begin
			result = WORD_MAX[`WORD_W-1:0];
		end else if (shifted < WORD_MIN) begin
			result = WORD_MIN[`WORD_W-1:0];
		end else begin
			result = shifted[`WORD_W-1:0];
		end
	end

	assign o_accepted = o_result_wr_en && i_result_re;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_result_wr_en <= 1'b0;
		end else if (i_load) begin
			o_result_wr_en <= 1'b1;
		end else if (o_accepted) begin
			o_result_wr_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) begin
			o_result_data <= result;
		end
	end

endmodule

// File: design/window_accumulator.sv
`timescale 1ns/100ps

module window_accumulator import cnn_pkg::*; (
	input  logic  clk,
	input  logic  i_reset,
	input  op_t   i_op_type,
	input  logic  i_fetch,
	input  logic  i_clear,
	input  logic  i_data_we,
	input  word_t i_data,
	input  logic  i_weight_we,
	input  word_t i_weight,
	output logic  o_data_rd_en,
	output logic  o_weight_rd_en,
	output logic  o_pair_done,
	output acc_t  o_acc
);

	logic is_conv;
	logic have_data;
	logic have_weight;
	logic first;
	logic take_data;
	logic take_weight;
	logic data_ok;
	logic weight_ok;
	logic complete;

	word_t data_q;
	word_t weight_q;
	word_t data_w;
	word_t weight_w;
	acc_t data_ext;
	acc_t product;
	acc_t acc;

	assign is_conv = (i_op_type == OP_CONV);

	// One request per word, held off until the element is consumed
	assign o_data_rd_en = i_fetch && !have_data;
	assign o_weight_rd_en = i_fetch && is_conv && !have_weight;

	assign take_data = o_data_rd_en && i_data_we;
	assign take_weight = o_weight_rd_en && i_weight_we;

	// Pooling needs no weight
	assign data_ok = have_data || take_data;
	assign weight_ok = !is_conv || have_weight || take_weight;
	assign complete = (take_data || take_weight) && data_ok && weight_ok;

	// Use the word arriving this cycle if it is the last one
	assign data_w = take_data ? i_data : data_q;
	assign weight_w = take_weight ? i_weight : weight_q;

	assign data_ext = acc_t'(data_w);
	assign product = acc_t'(data_w) * acc_t'(weight_w);

	always_ff @(posedge clk) begin
		if (i_reset || i_clear) begin
			have_data <= 1'b0;
			have_weight <= 1'b0;
			o_pair_done <= 1'b0;
			first <= 1'b1;
		end else begin
			o_pair_done <= complete;
			if (o_pair_done) begin
				have_data <= 1'b0;
				have_weight <= 1'b0;
			end else begin
				if (take_data) begin
					have_data <= 1'b1;
				end
				if (take_weight) begin
					have_weight <= 1'b1;
				end
			end
			if (complete) begin
				first <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_data) begin
			data_q <= i_data;
		end
		if (take_weight) begin
			weight_q <= i_weight;
		end
		if (complete) begin
			if (is_conv) begin
				acc <= first ? product : acc + product;
			end else if (first || data_ext > acc) begin
				acc <= data_ext;
			end
		end
	end

	assign o_acc = acc;

endmodule

// File: design/window_counter.sv
`timescale 1ns/100ps

module window_counter import cnn_pkg::*; (
	input  logic    clk,
	input  logic    i_reset,
	input  stride_t i_stride,
	input  count_t  i_kernel_size,
	input  count_t  i_o_count,
	input  addr_t   i_data_start_addr,
	input  addr_t   i_weight_start_addr,
	input  addr_t   i_result_start_addr,
	step_if.cnt     st,
	output addr_t   o_data_addr,
	output addr_t   o_weight_addr,
	output addr_t   o_result_addr
);

	// Element index within the window and output index
	count_t j;
	count_t k;

	addr_t window_base;
	addr_t weight_base;
	addr_t result_addr;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			j <= '0;
			k <= '0;
		end else if (st.start) begin
			j <= '0;
			k <= '0;
		end else if (st.advance) begin
			j <= '0;
			k <= k + count_t'(1);
		end else if (st.step) begin
			j <= j + count_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (st.start) begin
			window_base <= i_data_start_addr;
			weight_base <= i_weight_start_addr;
			result_addr <= i_result_start_addr;
		end else if (st.advance) begin
			// Window slides by the stride, one result slot per output
			window_base <= window_base + addr_t'(i_stride);
			result_addr <= result_addr + addr_t'(1);
		end
	end

	assign o_data_addr = window_base + addr_t'(j);
	assign o_weight_addr = weight_base + addr_t'(j);
	assign o_result_addr = result_addr;

	assign st.window_last = (j == i_kernel_size - count_t'(1));
	assign st.output_last = (k == i_o_count - count_t'(1));

endmodule

// File: design/engine_ctrl.sv
`timescale 1ns/100ps

module engine_ctrl import cnn_pkg::*; (
	input  logic   clk,
	input  logic   i_reset,
	input  logic   i_engine_valid,
	input  op_t    i_op_type,
	input  logic   i_pair_done,
	input  logic   i_accepted,
	step_if.ctrl   st,
	output logic   o_fetch,
	output logic   o_clear,
	output logic   o_load,
	output logic   o_engine_ready
);

	ctrl_state_t state;
	logic first_cycle;
	logic supported;

	assign supported = (i_op_type == OP_CONV) || (i_op_type == OP_MAXPOOL);

	// Counters load during the first FETCH cycle, reads begin after it
	assign st.start = first_cycle;
	assign o_fetch = (state == FETCH) && !first_cycle;

	assign st.step = (state == FETCH) && i_pair_done && !st.window_last;
	assign o_load = (state == FETCH) && i_pair_done && st.window_last;

	// Next window only once the held result has been taken
	assign st.advance = (state == WRITE) && i_accepted && !st.output_last;
	assign o_clear = first_cycle || st.advance;

	assign o_engine_ready = (state == DONE);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= IDLE;
			first_cycle <= 1'b0;
		end else begin
			first_cycle <= 1'b0;
			case (state)
				IDLE: begin
					if (i_engine_valid) begin
						if (supported) begin
							state <= FETCH;
							first_cycle <= 1'b1;
						end else begin
							// Unknown op finishes with no traffic
							state <= DONE;
						end
					end
				end
				FETCH: begin
					if (o_load) begin
						state <= WRITE;
					end
				end
				WRITE: begin
					if (i_accepted) begin
						if (st.output_last) begin
							state <= DONE;
						end else begin
							state <= FETCH;
						end
					end
				end
				DONE: begin
					state <= WAIT_LOW;
				end
				WAIT_LOW: begin
					// Level start must drop before the next run
					if (!i_engine_valid) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: design/step_if.sv
`timescale 1ns/100ps

interface step_if;

	logic start;
	logic step;
	logic advance;
	logic window_last;
	logic output_last;

	modport ctrl (
		output start,
		output step,
		output advance,
		input  window_last,
		input  output_last
	);

	modport cnt (
		input  start,
		input  step,
		input  advance,
		output window_last,
		output output_last
	);

endinterface

// File: design/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

	typedef logic signed [`WORD_W-1:0] word_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`CNT_W-1:0] count_t;
	typedef logic [3:0] stride_t;

	// Op codes follow the original engine numbering
	typedef enum logic [2:0] {
		OP_CONV    = 3'd1,
		OP_MAXPOOL = 3'd4
	} op_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		WRITE,
		DONE,
		WAIT_LOW
	} ctrl_state_t;

endpackage

// File: design/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// Data, weight and result word width
`define WORD_W 16

// Accumulator width for the sum of products
`define ACC_W 32

// DMA address width
`define ADDR_W 16

// Kernel size and output count width
`define CNT_W 8

// Q8.8 fraction bits
`define FRAC_BITS 8

`endif
